// ==== hw/isa_pkg.sv ====
package isa_pkg;

    parameter int XLEN     = 32;
    parameter int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             xlen_word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    // base opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111, // not issued by this stage
        op_jalr  = 7'b1100111, // not issued by this stage
        op_br    = 7'b1100011,
        op_load  = 7'b0000011, // not issued by this stage
        op_store = 7'b0100011, // not issued by this stage
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        add  = 3'b000, // sub when funct7[5] set on OP
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101, // srl or sra by funct7[5]
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_e;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_e;

    // decoded view of one queue entry
    typedef struct packed {
        xlen_word_t pc;
        opcode_e    opcode;
        logic [2:0] funct3;
        logic       funct7_b5;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        xlen_word_t i_imm;
        xlen_word_t u_imm;
        xlen_word_t b_imm;
    } instr_fields_t;

endpackage

// ==== hw/issue_pkg.sv ====
package issue_pkg;

    import isa_pkg::*;

    // tag 0 means no producer, register value is architectural
    parameter int TAG_W = 4;

    typedef logic [TAG_W-1:0] rob_tag_t;

    // encoding follows funct3 where it can
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        cls_none,
        cls_alu,
        cls_cmp,
        cls_drop
    } issue_class_e;

    typedef struct packed {
        xlen_word_t pc;
        xlen_word_t instr;
    } i_queue_data_t;

    typedef struct packed {
        xlen_word_t value;
        logic       valid;
        rob_tag_t   tag;
    } operand_t;

    typedef struct packed {
        operand_t rs1;
        operand_t rs2;
        alu_op_e  op;
        rob_tag_t rob_idx;
    } alu_entry_t;

    typedef struct packed {
        operand_t   rs1;
        operand_t   rs2;
        logic       br;     // low for slt/sltu
        logic [2:0] funct3;
        xlen_word_t pc;
        xlen_word_t b_imm;
        rob_tag_t   rob_idx;
    } cmp_entry_t;

    typedef struct packed {
        logic       valid;
        alu_entry_t entry;
    } alu_rs_t;

    typedef struct packed {
        logic       valid;
        cmp_entry_t entry;
    } cmp_rs_t;

    typedef struct packed {
        logic       valid;
        xlen_word_t pc;
        opcode_e    opcode;
        reg_idx_t   rd;
    } rob_alloc_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t rd;
    } rob_commit_t;

    typedef struct packed {
        rob_tag_t qj;
        rob_tag_t qk;
    } rob_query_t;

    typedef struct packed {
        logic       qj_ready;
        xlen_word_t qj_value;
        logic       qk_ready;
        xlen_word_t qk_value;
    } rob_reply_t;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
    } rf_read_t;

    typedef struct packed {
        xlen_word_t vj;
        xlen_word_t vk;
    } rf_data_t;

endpackage

// ==== hw/instr_decoder.sv ====
module instr_decoder
    import isa_pkg::*;
    import issue_pkg::*;
(
    input  i_queue_data_t i_queue_data_i,
    output instr_fields_t fields_o,
    output issue_class_e  class_o,
    output alu_op_e       alu_op_o
);

    xlen_word_t instr;
    logic       rd_zero;

    assign instr = i_queue_data_i.instr;

    // field extraction, immediates sign extended
    always_comb begin
        fields_o.pc        = i_queue_data_i.pc;
        fields_o.opcode    = opcode_e'(instr[6:0]);
        fields_o.funct3    = instr[14:12];
        fields_o.funct7_b5 = instr[30];
        fields_o.rs1       = instr[19:15];
        fields_o.rs2       = instr[24:20];
        fields_o.rd        = instr[11:7];
        fields_o.i_imm     = {{21{instr[31]}}, instr[30:20]};
        fields_o.u_imm     = {instr[31:12], 12'h000};
        fields_o.b_imm     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    end

    assign rd_zero = (fields_o.rd == '0);

    always_comb begin
        class_o = cls_none;
        case (fields_o.opcode)
            op_lui, op_auipc: begin
                class_o = rd_zero ? cls_drop : cls_alu;
            end
            op_imm, op_reg: begin
                if (rd_zero) begin
                    class_o = cls_drop; // no architectural effect
                end else if (fields_o.funct3 == slt || fields_o.funct3 == sltu) begin
                    class_o = cls_cmp;
                end else begin
                    class_o = cls_alu;
                end
            end
            op_br: begin
                case (branch_funct3_e'(fields_o.funct3))
                    beq, bne, blt, bge, bltu, bgeu: class_o = cls_cmp;
                    default: class_o = cls_none; // reserved funct3
                endcase
            end
            default: class_o = cls_none; // loads, stores, jumps, system
        endcase
    end

    // funct3/funct7 to alu op
    always_comb begin
        alu_op_o = alu_add;
        if (fields_o.opcode == op_lui || fields_o.opcode == op_auipc) begin
            alu_op_o = alu_add; // funct3 bits are immediate here
        end else begin
            case (arith_funct3_e'(fields_o.funct3))
                add: begin
                    if (fields_o.opcode == op_reg && fields_o.funct7_b5) begin
                        alu_op_o = alu_sub;
                    end else begin
                        alu_op_o = alu_add;
                    end
                end
                sll:  alu_op_o = alu_sll;
                sr:   alu_op_o = fields_o.funct7_b5 ? alu_sra : alu_srl;
                axor: alu_op_o = alu_xor;
                aor:  alu_op_o = alu_or;
                aand: alu_op_o = alu_and;
                default: alu_op_o = alu_add; // slt/sltu go to cmp anyway
            endcase
        end
    end

endmodule

// ==== hw/rename_table.sv ====
module rename_table
    import isa_pkg::*;
    import issue_pkg::*;
#(
    parameter int ROB_TAG_W = TAG_W
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 flush_i,
    input  reg_idx_t             rs1_i,
    input  reg_idx_t             rs2_i,
    output logic [ROB_TAG_W-1:0] qj_o,
    output logic [ROB_TAG_W-1:0] qk_o,
    input  logic                 alloc_i,
    input  reg_idx_t             alloc_rd_i,
    input  logic [ROB_TAG_W-1:0] alloc_tag_i,
    input  rob_commit_t          rob_commit_i
);

    logic [ROB_TAG_W-1:0] tags [NUM_REGS];

    // reads see the state before this cycle's write
    assign qj_o = tags[rs1_i];
    assign qk_o = tags[rs2_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                tags[i] <= '0;
            end
        end else if (flush_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                tags[i] <= '0;
            end
        end else begin
            for (int i = 1; i < NUM_REGS; i++) begin // x0 never renamed
                if (alloc_i && alloc_rd_i == reg_idx_t'(i)) begin
                    tags[i] <= alloc_tag_i; // new producer wins over commit
                end else if (rob_commit_i.valid && rob_commit_i.rd == reg_idx_t'(i)
                             && tags[i] == rob_commit_i.tag) begin
                    // only the youngest producer clears the entry
                    tags[i] <= '0;
                end
            end
        end
    end

endmodule

// ==== hw/dispatch_ctrl.sv ====
module dispatch_ctrl
    import isa_pkg::*;
    import issue_pkg::*;
#(
    parameter int ROB_TAG_W = TAG_W
) (
    input  instr_fields_t        fields_i,
    input  issue_class_e         class_i,
    input  alu_op_e              alu_op_i,
    input  logic                 i_queue_empty_i,
    input  logic                 flush_i,
    input  logic [ROB_TAG_W-1:0] qj_i,
    input  logic [ROB_TAG_W-1:0] qk_i,
    input  rf_data_t             rf_data_i,
    input  rob_reply_t           rob_reply_i,
    input  logic [ROB_TAG_W-1:0] rob_free_tag_i,
    input  logic                 alu_rs_full_i,
    input  logic                 cmp_rs_full_i,
    output logic                 pop_o,
    output logic                 alu_issue_o,
    output logic                 cmp_issue_o,
    output logic                 alloc_o,
    output alu_entry_t           alu_entry_o,
    output cmp_entry_t           cmp_entry_o,
    output rob_alloc_t           rob_alloc_o
);

    operand_t opnd_j;
    operand_t opnd_k;
    operand_t opnd_a;
    operand_t opnd_b;
    logic     base_ok;
    logic     rob_ok;
    logic     is_br;

    // tag 0 reads the regfile, a ready tag forwards from the rob
    function automatic operand_t resolve(input rob_tag_t   q,
                                         input xlen_word_t rf_val,
                                         input logic       rdy,
                                         input xlen_word_t rob_val);
        operand_t o;
        if (q == '0) begin
            o = '{value: rf_val, valid: 1'b1, tag: '0};
        end else if (rdy) begin
            o = '{value: rob_val, valid: 1'b1, tag: '0};
        end else begin
            o = '{value: '0, valid: 1'b0, tag: q}; // wait on producer
        end
        return o;
    endfunction

    assign opnd_j = resolve(qj_i, rf_data_i.vj, rob_reply_i.qj_ready, rob_reply_i.qj_value);
    assign opnd_k = resolve(qk_i, rf_data_i.vk, rob_reply_i.qk_ready, rob_reply_i.qk_value);

    assign is_br = (fields_i.opcode == op_br);

    // operand muxing per opcode
    always_comb begin
        opnd_a = opnd_j;
        opnd_b = opnd_k;
        case (fields_i.opcode)
            op_imm: begin
                opnd_b = '{value: fields_i.i_imm, valid: 1'b1, tag: '0};
            end
            op_lui: begin
                opnd_a = '{value: '0, valid: 1'b1, tag: '0};
                opnd_b = '{value: fields_i.u_imm, valid: 1'b1, tag: '0};
            end
            op_auipc: begin
                opnd_a = '{value: fields_i.pc, valid: 1'b1, tag: '0};
                opnd_b = '{value: fields_i.u_imm, valid: 1'b1, tag: '0};
            end
            default: ; // OP and branches use both registers
        endcase
    end

    // accept rule
    assign base_ok = !i_queue_empty_i && !flush_i;
    assign rob_ok  = (rob_free_tag_i != '0);

    always_comb begin
        alu_issue_o = 1'b0;
        cmp_issue_o = 1'b0;
        pop_o       = 1'b0;
        case (class_i)
            cls_alu: begin
                alu_issue_o = base_ok && rob_ok && !alu_rs_full_i;
                pop_o       = alu_issue_o;
            end
            cls_cmp: begin
                cmp_issue_o = base_ok && rob_ok && !cmp_rs_full_i;
                pop_o       = cmp_issue_o;
            end
            default: pop_o = base_ok; // drop and none are just discarded
        endcase
    end

    assign alloc_o = alu_issue_o || cmp_issue_o;

    assign alu_entry_o = '{rs1: opnd_a, rs2: opnd_b, op: alu_op_i, rob_idx: rob_free_tag_i};

    assign cmp_entry_o = '{
        rs1:     opnd_a,
        rs2:     opnd_b,
        br:      is_br,
        funct3:  fields_i.funct3,
        pc:      fields_i.pc,
        b_imm:   is_br ? fields_i.b_imm : '0,
        rob_idx: rob_free_tag_i
    };

    // branches write no register, rd bits are part of the offset
    assign rob_alloc_o = '{
        valid:  alloc_o,
        pc:     fields_i.pc,
        opcode: fields_i.opcode,
        rd:     is_br ? reg_idx_t'(0) : fields_i.rd
    };

endmodule

// ==== hw/issue_slot.sv ====
module issue_slot #(
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  logic   arst_n_i,
    input  logic   flush_i,
    input  logic   load_i,
    input  entry_t entry_i,
    output entry_t entry_o,
    output logic   valid_o
);

    entry_t entry_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= load_i; // one-cycle pulse per accept
        end
    end

    // payload holds until the next load
    always_ff @(posedge clk) begin
        if (load_i) begin
            entry_q <= entry_i;
        end
    end

    assign entry_o = entry_q;

endmodule

// ==== hw/decode_issue.sv ====
module decode_issue
    import isa_pkg::*;
    import issue_pkg::*;
#(
    parameter int ROB_TAG_W = TAG_W
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 flush_i,
    input  i_queue_data_t        i_queue_data_i,
    input  logic                 i_queue_empty_i,
    output logic                 i_queue_read_o,
    output rf_read_t             regfile_rd_o,
    input  rf_data_t             rf_data_i,
    input  logic [ROB_TAG_W-1:0] rob_free_tag_i,
    input  rob_commit_t          rob_commit_i,
    output rob_query_t           rob_query_o,
    input  rob_reply_t           rob_reply_i,
    output rob_alloc_t           rob_alloc_o,
    input  logic                 alu_rs_full_i,
    output alu_rs_t              alu_o,
    input  logic                 cmp_rs_full_i,
    output cmp_rs_t              cmp_o
);

    instr_fields_t        fields;
    issue_class_e         cls;
    alu_op_e              alu_op;
    logic [ROB_TAG_W-1:0] qj;
    logic [ROB_TAG_W-1:0] qk;
    logic                 alu_issue;
    logic                 cmp_issue;
    logic                 alloc;
    alu_entry_t           alu_entry;
    cmp_entry_t           cmp_entry;
    rob_alloc_t           rob_alloc_d;
    alu_entry_t           alu_entry_q;
    cmp_entry_t           cmp_entry_q;
    rob_alloc_t           rob_alloc_q;
    logic                 alu_valid;
    logic                 cmp_valid;
    logic                 alloc_valid;

    instr_decoder u_decoder (
        .i_queue_data_i (i_queue_data_i),
        .fields_o       (fields),
        .class_o        (cls),
        .alu_op_o       (alu_op)
    );

    rename_table #(.ROB_TAG_W(ROB_TAG_W)) u_rename (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .rs1_i        (fields.rs1),
        .rs2_i        (fields.rs2),
        .qj_o         (qj),
        .qk_o         (qk),
        .alloc_i      (alloc),
        .alloc_rd_i   (rob_alloc_d.rd), // 0 for branches
        .alloc_tag_i  (rob_free_tag_i),
        .rob_commit_i (rob_commit_i)
    );

    dispatch_ctrl #(.ROB_TAG_W(ROB_TAG_W)) u_dispatch (
        .fields_i        (fields),
        .class_i         (cls),
        .alu_op_i        (alu_op),
        .i_queue_empty_i (i_queue_empty_i),
        .flush_i         (flush_i),
        .qj_i            (qj),
        .qk_i            (qk),
        .rf_data_i       (rf_data_i),
        .rob_reply_i     (rob_reply_i),
        .rob_free_tag_i  (rob_free_tag_i),
        .alu_rs_full_i   (alu_rs_full_i),
        .cmp_rs_full_i   (cmp_rs_full_i),
        .pop_o           (i_queue_read_o),
        .alu_issue_o     (alu_issue),
        .cmp_issue_o     (cmp_issue),
        .alloc_o         (alloc),
        .alu_entry_o     (alu_entry),
        .cmp_entry_o     (cmp_entry),
        .rob_alloc_o     (rob_alloc_d)
    );

    issue_slot #(.entry_t(alu_entry_t)) u_alu_slot (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .load_i   (alu_issue),
        .entry_i  (alu_entry),
        .entry_o  (alu_entry_q),
        .valid_o  (alu_valid)
    );

    issue_slot #(.entry_t(cmp_entry_t)) u_cmp_slot (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .load_i   (cmp_issue),
        .entry_i  (cmp_entry),
        .entry_o  (cmp_entry_q),
        .valid_o  (cmp_valid)
    );

    issue_slot #(.entry_t(rob_alloc_t)) u_rob_slot (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .load_i   (alloc),
        .entry_i  (rob_alloc_d),
        .entry_o  (rob_alloc_q),
        .valid_o  (alloc_valid)
    );

    assign regfile_rd_o = '{rs1: fields.rs1, rs2: fields.rs2};
    assign rob_query_o  = '{qj: qj, qk: qk};

    assign alu_o = '{valid: alu_valid, entry: alu_entry_q};
    assign cmp_o = '{valid: cmp_valid, entry: cmp_entry_q};

    // slot valid replaces the stored flag
    assign rob_alloc_o = '{
        valid:  alloc_valid,
        pc:     rob_alloc_q.pc,
        opcode: rob_alloc_q.opcode,
        rd:     rob_alloc_q.rd
    };

endmodule

// ==== test/tb_decode_issue.sv ====
module tb_decode_issue
    import isa_pkg::*;
    import issue_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS    = 24;
    localparam int CYCLE_LIMIT = 10 + 3 * NUM_ROWS + 20;
    localparam rob_commit_t NO_COMMIT = '0;

    typedef struct packed {
        xlen_word_t  instr;
        xlen_word_t  pc;
        logic [3:0]  ctl;       // empty, flush, alu full, cmp full
        rob_tag_t    free_tag;
        rob_commit_t commit;
        rob_tag_t    fwd_tag;   // tag the rob reports ready, 0 for none
        xlen_word_t  fwd_val;
        logic [2:0]  exp_flags; // read strobe, alu valid, cmp valid
        alu_op_e     op;
    } row_t;

    logic          clk;
    logic          arst_n_i;
    logic          flush_i;
    i_queue_data_t i_queue_data_i;
    logic          i_queue_empty_i;
    logic          i_queue_read_o;
    rf_read_t      regfile_rd_o;
    rf_data_t      rf_data_i;
    rob_tag_t      rob_free_tag_i;
    rob_commit_t   rob_commit_i;
    rob_query_t    rob_query_o;
    rob_reply_t    rob_reply_i;
    rob_alloc_t    rob_alloc_o;
    logic          alu_rs_full_i;
    alu_rs_t       alu_o;
    logic          cmp_rs_full_i;
    cmp_rs_t       cmp_o;

    row_t       stim [NUM_ROWS];
    int         n_rows;
    rob_tag_t   model_tags [NUM_REGS];
    logic [15:0] rob_rdy;
    xlen_word_t rob_val [16];
    row_t       pend_row;
    int         pend_idx;
    operand_t   pend_a;
    operand_t   pend_b;
    rob_query_t exp_query;
    integer     seed;
    int         error_count;
    int         cycle_count;

    decode_issue #(.ROB_TAG_W(TAG_W)) dut (.*);

    always #50 clk = ~clk;

    // rob model answers the tag query in the same cycle
    assign rob_reply_i = '{
        qj_ready: (rob_query_o.qj != '0) && rob_rdy[rob_query_o.qj],
        qj_value: rob_val[rob_query_o.qj],
        qk_ready: (rob_query_o.qk != '0) && rob_rdy[rob_query_o.qk],
        qk_value: rob_val[rob_query_o.qk]
    };

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic xlen_word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3,
                                         input reg_idx_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                         input logic [2:0] f3, input reg_idx_t rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // branch offset is 13 bits, bit 0 always zero
    function automatic xlen_word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic xlen_word_t i_imm_of(input xlen_word_t w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic xlen_word_t u_imm_of(input xlen_word_t w);
        return w & 32'hffff_f000; // low 12 bits cleared
    endfunction

    // re-encoding the offset must give back the branch word
    function automatic logic branch_offset_ok(input xlen_word_t w, input xlen_word_t imm);
        return enc_b(imm[12:0], w[24:20], w[19:15], w[14:12]) == w && imm[0] == 1'b0
               && imm[31:13] == {19{imm[12]}};
    endfunction

    function automatic operand_t expect_operand(input rob_tag_t tag, input xlen_word_t rf_val);
        if (tag == '0) begin
            return '{value: rf_val, valid: 1'b1, tag: '0};
        end else if (rob_rdy[tag]) begin
            return '{value: rob_val[tag], valid: 1'b1, tag: '0}; // forwarded
        end
        return '{value: '0, valid: 1'b0, tag: tag};
    endfunction

    task automatic log_mismatch(input string msg);
        error_count++;
        $display("error at %0d ns: row %0d: %s", $time, pend_idx, msg);
    endtask

    task automatic add_row(input xlen_word_t instr, input xlen_word_t pc, input logic [3:0] ctl,
                           input rob_tag_t free_tag, input rob_commit_t commit,
                           input rob_tag_t fwd_tag, input xlen_word_t fwd_val,
                           input logic [2:0] exp_flags, input alu_op_e op);
        stim[n_rows] = '{instr, pc, ctl, free_tag, commit, fwd_tag, fwd_val, exp_flags, op};
        n_rows++;
    endtask

    task automatic build_rows();
        add_row(enc_r(7'h00, 3, 2, 3'b000, 1, op_reg), 32'h100, 4'b1000, 1, NO_COMMIT, 0, 0,
                3'b000, alu_add); // empty queue
        add_row(enc_r(7'h00, 3, 2, 3'b000, 1, op_reg), 32'h100, 4'b0000, 1, NO_COMMIT, 0, 0,
                3'b110, alu_add);
        add_row(enc_r(7'h20, 6, 5, 3'b000, 4, op_reg), 32'h104, 4'b0000, 2, NO_COMMIT, 0, 0,
                3'b110, alu_sub);
        add_row(enc_i(12'h403, 8, 3'b101, 7, op_imm), 32'h108, 4'b0000, 3, NO_COMMIT, 0, 0,
                3'b110, alu_sra);
        add_row(enc_i(12'hffb, 9, 3'b100, 8, op_imm), 32'h10c, 4'b0000, 4, NO_COMMIT, 0, 0,
                3'b110, alu_xor);
        add_row(enc_u(20'habcde, 9, op_lui), 32'h110, 4'b0000, 5, NO_COMMIT, 0, 0,
                3'b110, alu_add);
        add_row(enc_u(20'h12345, 10, op_auipc), 32'h1000, 4'b0000, 6, NO_COMMIT, 0, 0,
                3'b110, alu_add);
        add_row(enc_r(7'h00, 4, 1, 3'b000, 11, op_reg), 32'h1004, 4'b0000, 7, NO_COMMIT, 0, 0,
                3'b110, alu_add); // waits on tags 1 and 2
        add_row(enc_r(7'h00, 2, 1, 3'b000, 12, op_reg), 32'h1008, 4'b0000, 8, NO_COMMIT,
                1, 32'hdeadbeef, 3'b110, alu_add);
        add_row(enc_r(7'h00, 5, 4, 3'b000, 13, op_reg), 32'h100c, 4'b0000, 9, {1'b1, 4'd1, 5'd1},
                0, 0, 3'b110, alu_add);
        add_row(enc_r(7'h00, 7, 1, 3'b000, 14, op_reg), 32'h1010, 4'b0000, 10,
                {1'b1, 4'd2, 5'd7}, 0, 0, 3'b110, alu_add); // stale commit on x7
        add_row(enc_r(7'h00, 1, 7, 3'b000, 15, op_reg), 32'h1014, 4'b0000, 11, NO_COMMIT, 0, 0,
                3'b110, alu_add);
        add_row(enc_r(7'h00, 3, 2, 3'b010, 16, op_reg), 32'h200, 4'b0000, 12, NO_COMMIT, 0, 0,
                3'b101, alu_add);
        add_row(enc_i(12'd7, 3, 3'b011, 17, op_imm), 32'h204, 4'b0000, 13, NO_COMMIT, 0, 0,
                3'b101, alu_add);
        add_row(enc_b(13'h1ff0, 3, 2, 3'b000), 32'h2000, 4'b0000, 14, NO_COMMIT, 0, 0,
                3'b101, alu_add);
        add_row(enc_i(12'd1, 2, 3'b010, 0, op_imm), 32'h2004, 4'b0000, 15, NO_COMMIT, 0, 0,
                3'b100, alu_add); // rd 0, popped only
        add_row(enc_r(7'h00, 3, 2, 3'b000, 18, op_reg), 32'h2008, 4'b0010, 15, NO_COMMIT, 0, 0,
                3'b000, alu_add);
        add_row(enc_r(7'h00, 3, 2, 3'b000, 18, op_reg), 32'h2008, 4'b0000, 0, NO_COMMIT, 0, 0,
                3'b000, alu_add);
        add_row(enc_r(7'h00, 3, 2, 3'b000, 18, op_reg), 32'h2008, 4'b0000, 15, NO_COMMIT, 0, 0,
                3'b110, alu_add);
        add_row(enc_b(13'd8, 18, 1, 3'b001), 32'h200c, 4'b0001, 1, NO_COMMIT, 0, 0,
                3'b000, alu_add);
        add_row(enc_b(13'd8, 18, 1, 3'b001), 32'h200c, 4'b0000, 1, NO_COMMIT, 0, 0,
                3'b101, alu_add);
        add_row(enc_r(7'h00, 7, 4, 3'b000, 19, op_reg), 32'h2010, 4'b0100, 2, NO_COMMIT, 0, 0,
                3'b000, alu_add); // flush
        add_row(enc_r(7'h00, 7, 4, 3'b000, 19, op_reg), 32'h2010, 4'b0000, 2, NO_COMMIT, 0, 0,
                3'b110, alu_add);
        add_row(enc_r(7'h00, 3, 2, 3'b000, 1, op_reg), 32'h2014, 4'b1000, 3, NO_COMMIT, 0, 0,
                3'b000, alu_add);
    endtask

    task automatic drive_row(input row_t r);
        i_queue_data_i  = '{pc: r.pc, instr: r.instr};
        i_queue_empty_i = r.ctl[3];
        flush_i         = r.ctl[2];
        alu_rs_full_i   = r.ctl[1];
        cmp_rs_full_i   = r.ctl[0];
        rob_free_tag_i  = r.free_tag;
        rob_commit_i    = r.commit;
        rf_data_i.vj    = $random(seed);
        rf_data_i.vk    = $random(seed);
        rob_rdy         = '0;
        if (r.fwd_tag != '0) begin
            rob_rdy[r.fwd_tag] = 1'b1;
            rob_val[r.fwd_tag] = r.fwd_val;
        end
    endtask

    // expected entry from the tags before the edge, then the table update
    task automatic predict_row(input row_t r);
        opcode_e  opc;
        reg_idx_t rd;
        rob_tag_t next_tags [NUM_REGS];
        opc       = opcode_e'(r.instr[6:0]);
        rd        = r.instr[11:7];
        pend_row  = r;
        exp_query = '{qj: model_tags[r.instr[19:15]], qk: model_tags[r.instr[24:20]]};
        pend_a    = expect_operand(model_tags[r.instr[19:15]], rf_data_i.vj);
        pend_b    = expect_operand(model_tags[r.instr[24:20]], rf_data_i.vk);
        if (opc == op_imm) begin
            pend_b = '{value: i_imm_of(r.instr), valid: 1'b1, tag: '0};
        end else if (opc == op_lui || opc == op_auipc) begin
            pend_a = '{value: (opc == op_lui) ? '0 : r.pc, valid: 1'b1, tag: '0};
            pend_b = '{value: u_imm_of(r.instr), valid: 1'b1, tag: '0};
        end
        next_tags = model_tags;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (r.ctl[2]) begin
                next_tags[i] = '0;
            end
        end
        if (!r.ctl[2]) begin
            if (r.commit.valid && r.commit.rd != '0
                && model_tags[r.commit.rd] == r.commit.tag) begin
                next_tags[r.commit.rd] = '0;
            end
            if (r.exp_flags[1:0] != 2'b00 && opc != op_br && rd != '0) begin
                next_tags[rd] = r.free_tag; // issue overrides a commit
            end
        end
        model_tags = next_tags;
    endtask

    task automatic check_operand(input string name, input operand_t got, input operand_t exp);
        assert (got.valid == exp.valid && got.tag == exp.tag) else
            log_mismatch($sformatf("%s valid/tag %0b/%0d, expected %0b/%0d",
                                   name, got.valid, got.tag, exp.valid, exp.tag));
        if (exp.valid) begin
            assert (got.value == exp.value) else
                log_mismatch($sformatf("%s value %h, expected %h", name, got.value, exp.value));
        end
    endtask

    task automatic check_outputs();
        row_t    r;
        opcode_e opc;
        logic    is_br;
        r     = pend_row;
        opc   = opcode_e'(r.instr[6:0]);
        is_br = (opc == op_br);
        assert (alu_o.valid == r.exp_flags[1] && cmp_o.valid == r.exp_flags[0]) else
            log_mismatch($sformatf("alu/cmp valid %0b/%0b, expected %0b/%0b",
                                   alu_o.valid, cmp_o.valid, r.exp_flags[1], r.exp_flags[0]));
        assert (rob_alloc_o.valid == (|r.exp_flags[1:0])) else
            log_mismatch($sformatf("rob alloc valid %0b", rob_alloc_o.valid));
        if (r.exp_flags[1]) begin
            assert (alu_o.entry.op == r.op && alu_o.entry.rob_idx == r.free_tag) else
                log_mismatch($sformatf("alu op %0d tag %0d, expected %0d tag %0d",
                             alu_o.entry.op, alu_o.entry.rob_idx, r.op, r.free_tag));
            check_operand("alu rs1", alu_o.entry.rs1, pend_a);
            check_operand("alu rs2", alu_o.entry.rs2, pend_b);
        end
        if (r.exp_flags[0]) begin
            assert (cmp_o.entry.br == is_br && cmp_o.entry.funct3 == r.instr[14:12]
                    && cmp_o.entry.pc == r.pc && cmp_o.entry.rob_idx == r.free_tag) else
                log_mismatch($sformatf("cmp br %0b funct3 %0d pc %h tag %0d", cmp_o.entry.br,
                             cmp_o.entry.funct3, cmp_o.entry.pc, cmp_o.entry.rob_idx));
            if (is_br) begin
                assert (branch_offset_ok(r.instr, cmp_o.entry.b_imm)) else
                    log_mismatch($sformatf("branch offset %h", cmp_o.entry.b_imm));
            end
            check_operand("cmp rs1", cmp_o.entry.rs1, pend_a);
            check_operand("cmp rs2", cmp_o.entry.rs2, pend_b);
        end
        if (|r.exp_flags[1:0]) begin
            assert (rob_alloc_o.pc == r.pc && rob_alloc_o.opcode == opc
                    && (is_br || rob_alloc_o.rd == r.instr[11:7])) else
                log_mismatch($sformatf("rob alloc pc %h rd %0d", rob_alloc_o.pc, rob_alloc_o.rd));
        end
    endtask

    initial begin
        clk             = 1'b0;
        arst_n_i        = 1'b0;
        flush_i         = 1'b0;
        i_queue_data_i  = '0;
        i_queue_empty_i = 1'b1;
        rf_data_i       = '0;
        rob_free_tag_i  = '0;
        rob_commit_i    = '0;
        alu_rs_full_i   = 1'b0;
        cmp_rs_full_i   = 1'b0;
        rob_rdy         = '0;
        seed            = 79807;
        error_count     = 0;
        cycle_count     = 0;
        n_rows          = 0;
        pend_row        = '0; // first check sees the idle state after reset
        pend_idx        = -1;
        exp_query       = '0;
        for (int i = 0; i < 16; i++) begin
            rob_val[i] = '0;
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            model_tags[i] = '0;
        end
        build_rows();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk);
            check_outputs();
            pend_idx = i;
            drive_row(stim[i]);
            predict_row(stim[i]);
            #10;
            assert (i_queue_read_o == stim[i].exp_flags[2]) else
                log_mismatch($sformatf("queue read %0b, expected %0b",
                                       i_queue_read_o, stim[i].exp_flags[2]));
            assert (regfile_rd_o.rs1 == stim[i].instr[19:15]
                    && regfile_rd_o.rs2 == stim[i].instr[24:20]) else
                log_mismatch("register file read address");
            assert (rob_query_o == exp_query) else
                log_mismatch($sformatf("rob query %0d/%0d, expected %0d/%0d",
                                       rob_query_o.qj, rob_query_o.qk,
                                       exp_query.qj, exp_query.qk));
        end
        @(negedge clk);
        check_outputs();
        $display("rows applied: %0d, errors: %0d", NUM_ROWS, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== decode_issue.f ====
hw/isa_pkg.sv
hw/issue_pkg.sv
hw/instr_decoder.sv
hw/rename_table.sv
hw/dispatch_ctrl.sv
hw/issue_slot.sv
hw/decode_issue.sv
test/tb_decode_issue.sv
